//--- design/ptw_pkg.sv
/*
 * Sv39 page-table walker shared definitions
 * - address, PTE and identifier types
 * - walk level, walk state and PTE class enums
 * - PTE flag positions and walk field widths
 */

`default_nettype none

package ptw_pkg;

    // bus and identifier widths
    localparam int unsigned PlenWidth  = 56;
    localparam int unsigned IovaWidth  = 39;
    localparam int unsigned PpnWidth   = 44;
    localparam int unsigned PteWidth   = 64;
    localparam int unsigned PscidWidth = 20;

    // page offset and per-level vpn slice
    localparam int unsigned PageOffsetW  = 12;
    localparam int unsigned VpnSliceW    = 9;
    // entries are 8 bytes
    localparam int unsigned PteBytesLog2 = 3;
    localparam int unsigned VpnWidth     = IovaWidth - PageOffsetW;

    // pte flag bit positions
    localparam int unsigned PteV = 0;
    localparam int unsigned PteR = 1;
    localparam int unsigned PteW = 2;
    localparam int unsigned PteX = 3;
    localparam int unsigned PteU = 4;
    localparam int unsigned PteG = 5;
    localparam int unsigned PteA = 6;
    localparam int unsigned PteD = 7;
    // ppn field of the pte
    localparam int unsigned PpnLsb = 10;
    localparam int unsigned PpnMsb = PpnLsb + PpnWidth - 1;

    typedef logic [PlenWidth-1:0]  plen_t;
    typedef logic [IovaWidth-1:0]  iova_t;
    typedef logic [PpnWidth-1:0]   ppn_t;
    typedef logic [VpnWidth-1:0]   vpn_t;
    typedef logic [PteWidth-1:0]   pte_t;
    typedef logic [PscidWidth-1:0] pscid_t;

    // LVL1 is the 1G root table, LVL3 holds 4K leaves
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } ptw_state_e;

    typedef enum logic [1:0] {
        PTE_LEAF,
        PTE_POINTER,
        PTE_FAULT
    } pte_kind_e;

endpackage

`default_nettype wire

//--- design/ptw_ctrl.sv
/*
 * Walk FSM of the Sv39 page-table walker
 * - miss capture and memory request sequencing
 * - per-entry decision: next level, IOTLB update or fault
 */

`timescale 1ns/1ps
`default_nettype none

module ptw_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 iotlb_access_i,
    input  logic                 iotlb_hit_i,
    input  logic                 mem_gnt_i,
    input  logic                 pte_valid_i,
    input  ptw_pkg::pte_kind_e   pte_kind_i,
    input  logic                 is_last_lvl_i,
    output logic                 mem_req_o,
    output logic                 capture_o,
    output logic                 advance_o,
    output logic                 update_o,
    output logic                 ptw_error_o,
    output logic                 ptw_active_o
);
    import ptw_pkg::*;

    ptw_state_e state_q, state_d;
    logic       mem_req_q;
    logic       miss;

    // a lookup in the IOTLB that missed
    assign miss = iotlb_access_i & ~iotlb_hit_i;

    assign ptw_active_o = (state_q != IDLE);
    assign mem_req_o    = mem_req_q;

    always_comb begin
        state_d     = state_q;
        capture_o   = 1'b0;
        advance_o   = 1'b0;
        update_o    = 1'b0;
        ptw_error_o = 1'b0;

        case (state_q)
            // only here is a miss taken, busy misses are dropped
            IDLE: begin
                if (miss) begin
                    capture_o = 1'b1;
                    state_d   = WAIT_GRANT;
                end
            end
            // request held until the grant cycle
            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end
            // wait for the registered entry, then decide in the same cycle
            PTE_LOOKUP: begin
                if (pte_valid_i) begin
                    case (pte_kind_i)
                        PTE_LEAF: begin
                            update_o = 1'b1;
                            state_d  = IDLE;
                        end
                        PTE_POINTER: begin
                            advance_o = 1'b1;
                            state_d   = WAIT_GRANT;
                        end
                        default: begin
                            state_d = PROPAGATE_ERROR;
                        end
                    endcase
                end
            end
            // one-cycle fault pulse
            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            mem_req_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            // request follows the state, asserted on entry to WAIT_GRANT
            mem_req_q <= (state_d == WAIT_GRANT);
        end
    end

    // an entry only comes back while the FSM waits for one
    rsp_in_lookup_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pte_valid_i |-> (state_q == PTE_LOOKUP));

    // a pointer out of the 4K table is classified as a fault upstream
    no_ptr_at_last_lvl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pte_valid_i && (pte_kind_i == PTE_POINTER)) |-> !is_last_lvl_i);

endmodule

`default_nettype wire

//--- design/ptw_ptr_gen.sv
/*
 * PTE pointer generator
 * - captured IOVA and PSCID of the walk
 * - current walk level
 * - root and next-level PTE address arithmetic
 */

`timescale 1ns/1ps
`default_nettype none

module ptw_ptr_gen (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               capture_i,
    input  logic               advance_i,
    input  ptw_pkg::iova_t     req_iova_i,
    input  ptw_pkg::pscid_t    pscid_i,
    input  ptw_pkg::ppn_t      iosatp_ppn_i,
    input  ptw_pkg::pte_t      pte_i,
    output ptw_pkg::plen_t     mem_addr_o,
    output ptw_pkg::ptw_lvl_e  lvl_o,
    output logic               is_last_lvl_o,
    output ptw_pkg::iova_t     iova_o,
    output ptw_pkg::pscid_t    pscid_o
);
    import ptw_pkg::*;

    ptw_lvl_e              lvl_q;
    iova_t                 iova_q;
    pscid_t                pscid_q;
    plen_t                 pptr_q;
    ppn_t                  pte_ppn;
    logic [VpnSliceW-1:0]  next_slice;

    // next table base from the pointer entry
    assign pte_ppn = pte_i[PpnMsb:PpnLsb];

    // VPN[1] after the root table, VPN[0] after the second
    always_comb begin
        if (lvl_q == LVL1) begin
            next_slice = iova_q[PageOffsetW+VpnSliceW +: VpnSliceW];
        end else begin
            next_slice = iova_q[PageOffsetW +: VpnSliceW];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q <= LVL1;
        end else if (capture_i) begin
            lvl_q <= LVL1;
        end else if (advance_i) begin
            lvl_q <= (lvl_q == LVL1) ? LVL2 : LVL3;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            iova_q  <= req_iova_i;
            pscid_q <= pscid_i;
            // root entry indexed by VPN[2]
            pptr_q  <= {iosatp_ppn_i, req_iova_i[PageOffsetW+2*VpnSliceW +: VpnSliceW],
                        {PteBytesLog2{1'b0}}};
        end else if (advance_i) begin
            pptr_q  <= {pte_ppn, next_slice, {PteBytesLog2{1'b0}}};
        end
    end

    assign mem_addr_o    = pptr_q;
    assign lvl_o         = lvl_q;
    assign is_last_lvl_o = (lvl_q == LVL3);
    assign iova_o        = iova_q;
    assign pscid_o       = pscid_q;

    // controller must not step past the 4K table
    no_advance_at_lvl3_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        advance_i |-> (lvl_q != LVL3));

endmodule

`default_nettype wire

//--- design/pte_check.sv
/*
 * PTE response capture and classification
 * - registered read data and read valid
 * - leaf, pointer or fault decision per Sv39 rules
 */

`timescale 1ns/1ps
`default_nettype none

module pte_check (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                mem_rvalid_i,
    input  ptw_pkg::pte_t       mem_rdata_i,
    input  ptw_pkg::ptw_lvl_e   lvl_i,
    output ptw_pkg::pte_t       pte_o,
    output logic                pte_valid_o,
    output ptw_pkg::pte_kind_e  pte_kind_o
);
    import ptw_pkg::*;

    pte_t  rdata_q;
    logic  rvalid_q;
    ppn_t  ppn;
    logic  is_leaf;
    logic  bad_encoding;
    logic  misaligned;
    logic  bad_pointer;
    logic  bad_upper;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rvalid_i;
        end
    end

    // entry held until the next response
    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign ppn     = rdata_q[PpnMsb:PpnLsb];
    assign is_leaf = rdata_q[PteR] | rdata_q[PteX];

    // V clear, or writable without readable
    assign bad_encoding = ~rdata_q[PteV] | (rdata_q[PteW] & ~rdata_q[PteR]);

    // superpage leaves need the low ppn bits clear
    always_comb begin
        misaligned = 1'b0;
        if (is_leaf) begin
            case (lvl_i)
                LVL1:    misaligned = |ppn[2*VpnSliceW-1:0];
                LVL2:    misaligned = |ppn[VpnSliceW-1:0];
                default: misaligned = 1'b0;
            endcase
        end
    end

    // A, D and U are reserved on pointers, and LVL3 cannot point further
    assign bad_pointer = ~is_leaf &
        (rdata_q[PteA] | rdata_q[PteD] | rdata_q[PteU] | (lvl_i == LVL3));

    // nothing may sit above the 44-bit ppn
    assign bad_upper = |rdata_q[PteWidth-1:PpnMsb+1];

    always_comb begin
        if (bad_encoding || misaligned || bad_pointer || bad_upper) begin
            pte_kind_o = PTE_FAULT;
        end else if (is_leaf) begin
            pte_kind_o = PTE_LEAF;
        end else begin
            pte_kind_o = PTE_POINTER;
        end
    end

    assign pte_o       = rdata_q;
    assign pte_valid_o = rvalid_q;

endmodule

`default_nettype wire

//--- design/iotlb_update_gen.sv
/*
 * IOTLB update field generation
 * - global-mapping accumulator over the walk
 * - VPN, content and page size of the update
 */

`timescale 1ns/1ps
`default_nettype none

module iotlb_update_gen (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               capture_i,
    input  logic               pte_valid_i,
    input  ptw_pkg::pte_t      pte_i,
    input  ptw_pkg::ptw_lvl_e  lvl_i,
    input  ptw_pkg::iova_t     iova_i,
    output ptw_pkg::vpn_t      up_vpn_o,
    output ptw_pkg::pte_t      up_content_o,
    output logic               up_is_2m_o,
    output logic               up_is_1g_o
);
    import ptw_pkg::*;

    logic global_q;

    // sticky G over every entry read in this walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (capture_i) begin
            global_q <= 1'b0;
        end else if (pte_valid_i && pte_i[PteG]) begin
            global_q <= 1'b1;
        end
    end

    // leaf's own G is folded in directly, its register update comes a cycle late
    always_comb begin
        up_content_o       = pte_i;
        up_content_o[PteG] = global_q | pte_i[PteG];
    end

    assign up_vpn_o   = iova_i[IovaWidth-1:PageOffsetW];
    // leaf level gives the page size
    assign up_is_2m_o = (lvl_i == LVL2);
    assign up_is_1g_o = (lvl_i == LVL1);

endmodule

`default_nettype wire

//--- design/iommu_ptw_top.sv
/*
 * Sv39 IOMMU page-table walker top level
 * - walk FSM, pointer generator, PTE check and update generator
 */

`timescale 1ns/1ps
`default_nettype none

module iommu_ptw_top (
    input  logic             clk_i,
    input  logic             rst_ni,
    // IOTLB miss
    input  logic             iotlb_access_i,
    input  logic             iotlb_hit_i,
    input  ptw_pkg::iova_t   req_iova_i,
    input  ptw_pkg::pscid_t  pscid_i,
    input  ptw_pkg::ppn_t    iosatp_ppn_i,
    // memory read port
    output logic             mem_req_o,
    output ptw_pkg::plen_t   mem_addr_o,
    input  logic             mem_gnt_i,
    input  logic             mem_rvalid_i,
    input  ptw_pkg::pte_t    mem_rdata_i,
    // IOTLB update
    output logic             update_o,
    output ptw_pkg::vpn_t    up_vpn_o,
    output ptw_pkg::pscid_t  up_pscid_o,
    output ptw_pkg::pte_t    up_content_o,
    output logic             up_is_2m_o,
    output logic             up_is_1g_o,
    // status
    output logic             ptw_error_o,
    output logic             ptw_active_o
);
    import ptw_pkg::*;

    logic       capture;
    logic       advance;
    logic       pte_valid;
    pte_kind_e  pte_kind;
    logic       is_last_lvl;
    ptw_lvl_e   lvl;
    iova_t      iova;
    pte_t       pte;

    ptw_ctrl i_ctrl (
        .clk_i, .rst_ni, .iotlb_access_i, .iotlb_hit_i, .mem_gnt_i,
        .pte_valid_i(pte_valid), .pte_kind_i(pte_kind), .is_last_lvl_i(is_last_lvl),
        .mem_req_o, .capture_o(capture), .advance_o(advance),
        .update_o, .ptw_error_o, .ptw_active_o
    );

    ptw_ptr_gen i_ptr_gen (
        .clk_i, .rst_ni, .capture_i(capture), .advance_i(advance),
        .req_iova_i, .pscid_i, .iosatp_ppn_i, .pte_i(pte),
        .mem_addr_o, .lvl_o(lvl), .is_last_lvl_o(is_last_lvl),
        .iova_o(iova), .pscid_o(up_pscid_o)
    );

    pte_check i_pte_check (
        .clk_i, .rst_ni, .mem_rvalid_i, .mem_rdata_i, .lvl_i(lvl),
        .pte_o(pte), .pte_valid_o(pte_valid), .pte_kind_o(pte_kind)
    );

    iotlb_update_gen i_update_gen (
        .clk_i, .rst_ni, .capture_i(capture), .pte_valid_i(pte_valid),
        .pte_i(pte), .lvl_i(lvl), .iova_i(iova),
        .up_vpn_o, .up_content_o, .up_is_2m_o, .up_is_1g_o
    );

endmodule

`default_nettype wire

//--- dv/tb_iommu_ptw.sv
/*
 * Testbench for the Sv39 IOMMU page-table walker
 * - clock, reset and a page-table memory with random grant and read delays
 * - reference walk, directed and random walks, result compare and report
 */

`timescale 1ns/1ps
`default_nettype none

module tb_iommu_ptw;
    import ptw_pkg::*;

    localparam int NumRandom = 40;
    localparam int NumTests  = 13 + NumRandom;
    // worst case is three levels of eight cycles each
    localparam int MaxCycles = NumTests * 3 * 8 + 400;

    typedef struct packed {
        logic       is_fault;
        vpn_t       vpn;
        pte_t       content;
        logic       is_2m;
        logic       is_1g;
        pscid_t     pscid;
        logic [1:0] nreads;
    } walk_exp_t;

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    iotlb_access_i;
    logic    iotlb_hit_i;
    iova_t   req_iova_i;
    pscid_t  pscid_i;
    ppn_t    iosatp_ppn_i;
    logic    mem_req_o;
    plen_t   mem_addr_o;
    logic    mem_gnt_i;
    logic    mem_rvalid_i;
    pte_t    mem_rdata_i;
    logic    update_o;
    vpn_t    up_vpn_o;
    pscid_t  up_pscid_o;
    pte_t    up_content_o;
    logic    up_is_2m_o;
    logic    up_is_1g_o;
    logic    ptw_error_o;
    logic    ptw_active_o;

    // page tables of the current test
    pte_t       mem [plen_t];
    walk_exp_t  expected;
    string      test_name;
    logic       pending = 1'b0;
    logic       idle_probe = 1'b0;
    int         reads = 0;
    int         reads_at_start = 0;
    int         done_count = 0;
    int         errors = 0;
    int         test_errors = 0;
    int         protocol_errors = 0;
    int         cycles = 0;

    iommu_ptw_top i_dut (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > MaxCycles) begin
            $display("timeout, walker gave no result within %0d cycles", MaxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [9:0] flag(input int unsigned pos);
        return 10'(1) << pos;
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic [9:0] flags,
                                      input logic [9:0] upper);
        return {upper, ppn, flags};
    endfunction

    function automatic pte_t ptr_to(input ppn_t ppn);
        return make_pte(ppn, flag(PteV), 10'h0);
    endfunction

    // low ppn bits that a superpage at this level must keep clear
    function automatic ppn_t low_mask(input int lvl);
        return (ppn_t'(1) << (VpnSliceW * lvl)) - ppn_t'(1);
    endfunction

    // lvl 2 is the root table, lvl 0 the 4K table
    function automatic plen_t entry_addr(input ppn_t base, input iova_t iova, input int lvl);
        return {base, iova[PageOffsetW + VpnSliceW * lvl +: VpnSliceW], {PteBytesLog2{1'b0}}};
    endfunction

    function automatic walk_exp_t walk_ref(input iova_t iova, input pscid_t pscid,
                                           input ppn_t root);
        walk_exp_t r;
        ppn_t      base;
        pte_t      p;
        plen_t     a;
        logic      g;
        logic      leaf;
        logic      fault;
        r       = '0;
        r.vpn   = iova[IovaWidth-1:PageOffsetW];
        r.pscid = pscid;
        base    = root;
        g       = 1'b0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            a        = entry_addr(base, iova, lvl);
            p        = mem.exists(a) ? mem[a] : '0;
            r.nreads = r.nreads + 2'd1;
            g        = g | p[PteG];
            leaf     = p[PteR] | p[PteX];
            fault    = !p[PteV] || (p[PteW] && !p[PteR]) || (p[PteWidth-1:PpnMsb+1] != '0)
                       || (leaf && ((p[PpnMsb:PpnLsb] & low_mask(lvl)) != '0))
                       || (!leaf && (p[PteA] || p[PteD] || p[PteU] || lvl == 0));
            if (fault || leaf) begin
                r.is_fault      = fault;
                r.content       = p;
                r.content[PteG] = g;
                r.is_2m         = (lvl == 1);
                r.is_1g         = (lvl == 2);
                return r;
            end
            base = p[PpnMsb:PpnLsb];
        end
        return r;
    endfunction

    // mostly pointers and aligned leaves, some raw flags and dirty upper bits
    function automatic pte_t rand_pte(input int lvl);
        int unsigned kind;
        ppn_t        ppn;
        logic [9:0]  flags;
        logic [9:0]  upper;
        kind  = $urandom_range(0, 9);
        ppn   = ppn_t'({$urandom, $urandom});
        flags = 10'($urandom);
        upper = 10'h0;
        if (kind < 5) begin
            flags = flag(PteV) | (flags & flag(PteG));
        end else if (kind < 8) begin
            flags = flags | flag(PteV) | flag(PteR);
            ppn   = ppn & ~low_mask(lvl);
        end else if (kind == 9) begin
            upper = 10'($urandom);
        end
        return make_pte(ppn, flags, upper);
    endfunction

    // one entry per level along the path of this iova
    task automatic set_chain(input ppn_t root, input iova_t iova, input pte_t e2,
                             input pte_t e1, input pte_t e0);
        mem.delete();
        mem[entry_addr(root, iova, 2)]               = e2;
        mem[entry_addr(e2[PpnMsb:PpnLsb], iova, 1)] = e1;
        mem[entry_addr(e1[PpnMsb:PpnLsb], iova, 0)] = e0;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_pte(input string name, input pte_t got, input pte_t want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic check_vpn(input string name, input vpn_t got, input vpn_t want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic check_pscid(input string name, input pscid_t got, input pscid_t want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic finish_test();
        $display("test %0d %s: %s", done_count + 1, test_name,
                 (test_errors == 0) ? "ok" : "mismatch");
        test_errors = 0;
        done_count++;
    endtask

    task automatic compare_result();
        if (!pending) begin
            $display("result pulse at %0t with no walk in progress", $time);
            note_error();
            return;
        end
        check_bit("ptw_error_o", ptw_error_o, expected.is_fault);
        check_bit("update_o", update_o, !expected.is_fault);
        // walker still busy while its result is out
        check_bit("ptw_active_o", ptw_active_o, 1'b1);
        if (!expected.is_fault) begin
            check_vpn("up_vpn_o", up_vpn_o, expected.vpn);
            check_pscid("up_pscid_o", up_pscid_o, expected.pscid);
            check_pte("up_content_o", up_content_o, expected.content);
            check_bit("up_is_2m_o", up_is_2m_o, expected.is_2m);
            check_bit("up_is_1g_o", up_is_1g_o, expected.is_1g);
        end
        // walker back in IDLE one cycle after the result
        @(negedge clk_i);
        check_bit("ptw_active_o", ptw_active_o, 1'b0);
        check_count("memory reads", reads - reads_at_start, int'(expected.nreads));
        finish_test();
    endtask

    // results are sampled mid-cycle
    initial begin : result_monitor
        forever begin
            @(negedge clk_i);
            if (update_o || ptw_error_o) begin
                compare_result();
            end else if (idle_probe) begin
                check_bit("ptw_active_o", ptw_active_o, 1'b0);
                check_count("memory reads", reads - reads_at_start, 0);
                finish_test();
            end
        end
    end

    initial begin : memory_model
        plen_t addr;
        int    gnt_wait;
        int    rd_wait;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            #2;
            if (mem_req_o) begin
                addr     = mem_addr_o;
                gnt_wait = $urandom_range(0, 3);
                rd_wait  = $urandom_range(1, 3);
                // request must hold still until granted
                repeat (gnt_wait) begin
                    @(posedge clk_i);
                    #2;
                    if (!mem_req_o || mem_addr_o !== addr) begin
                        $display("CHECK FAILED t=%0t mem_addr_o got %h expected %h req %b",
                                 $time, mem_addr_o, addr, mem_req_o);
                        protocol_errors++;
                    end
                end
                mem_gnt_i = 1'b1;
                reads++;
                @(posedge clk_i);
                #2;
                mem_gnt_i = 1'b0;
                repeat (rd_wait - 1) begin
                    @(posedge clk_i);
                    #2;
                end
                // unmapped addresses read as an invalid entry
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = mem.exists(addr) ? mem[addr] : '0;
                @(posedge clk_i);
                #2;
                mem_rvalid_i = 1'b0;
                mem_rdata_i  = '0;
            end
        end
    end

    task automatic run_walk(input string name, input iova_t iova, input pscid_t pscid,
                            input ppn_t root, input logic busy_miss);
        int target;
        expected       = walk_ref(iova, pscid, root);
        test_name      = name;
        target         = done_count + 1;
        @(posedge clk_i);
        #2;
        reads_at_start = reads;
        pending        = 1'b1;
        req_iova_i     = iova;
        pscid_i        = pscid;
        iosatp_ppn_i   = root;
        iotlb_access_i = 1'b1;
        iotlb_hit_i    = 1'b0;
        @(posedge clk_i);
        #2;
        iotlb_access_i = 1'b0;
        if (busy_miss) begin
            // a second miss while walking must be dropped
            req_iova_i     = ~iova;
            pscid_i        = ~pscid;
            iotlb_access_i = 1'b1;
            @(posedge clk_i);
            #2;
            iotlb_access_i = 1'b0;
        end
        wait (done_count == target);
        pending = 1'b0;
    endtask

    task automatic run_hit(input string name);
        int target;
        test_name = name;
        target    = done_count + 1;
        @(posedge clk_i);
        #2;
        reads_at_start = reads;
        iotlb_access_i = 1'b1;
        iotlb_hit_i    = 1'b1;
        @(posedge clk_i);
        #2;
        iotlb_access_i = 1'b0;
        iotlb_hit_i    = 1'b0;
        repeat (4) @(posedge clk_i);
        idle_probe = 1'b1;
        wait (done_count == target);
        idle_probe = 1'b0;
    endtask

    initial begin : stimulus
        iova_t root_iova;
        iova_t iova;
        ppn_t  root;
        pte_t  leaf_4k;
        void'($urandom(32'h0a32_5533));
        rst_ni         = 1'b0;
        iotlb_access_i = 1'b0;
        iotlb_hit_i    = 1'b0;
        req_iova_i     = '0;
        pscid_i        = '0;
        iosatp_ppn_i   = '0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        root      = 44'h100;
        root_iova = {9'h0a5, 9'h13c, 9'h1f0, 12'habc};
        leaf_4k   = make_pte(44'h12345, flag(PteV) | flag(PteR) | flag(PteW) | flag(PteA)
                             | flag(PteD), 10'h0);
        set_chain(root, root_iova, ptr_to(44'h200), ptr_to(44'h300), leaf_4k);
        run_walk("walk_4k", root_iova, 20'habcde, root, 1'b0);
        // G only on the root pointer
        set_chain(root, root_iova, make_pte(44'h200, flag(PteV) | flag(PteG), 10'h0),
                  make_pte(44'h400, flag(PteV) | flag(PteR) | flag(PteX), 10'h0), '0);
        run_walk("leaf_2m_global", root_iova, 20'h00011, root, 1'b0);
        set_chain(root, root_iova, make_pte(44'h4_0000, flag(PteV) | flag(PteR) | flag(PteG),
                  10'h0), '0, '0);
        run_walk("leaf_1g", root_iova, 20'h00022, root, 1'b0);

        set_chain(root, root_iova, ptr_to(44'h200), make_pte(44'h300, 10'h0, 10'h0), '0);
        run_walk("fault_invalid", root_iova, 20'h00033, root, 1'b0);
        set_chain(root, root_iova, ptr_to(44'h200),
                  make_pte(44'h300, flag(PteV) | flag(PteW), 10'h0), '0);
        run_walk("fault_w_no_r", root_iova, 20'h00044, root, 1'b0);
        set_chain(root, root_iova, ptr_to(44'h200),
                  make_pte(44'h401, flag(PteV) | flag(PteR), 10'h0), '0);
        run_walk("fault_misaligned", root_iova, 20'h00055, root, 1'b0);
        set_chain(root, root_iova, make_pte(44'h200, flag(PteV) | flag(PteA), 10'h0), '0, '0);
        run_walk("fault_ptr_a", root_iova, 20'h00066, root, 1'b0);
        set_chain(root, root_iova, ptr_to(44'h200),
                  make_pte(44'h300, flag(PteV) | flag(PteD), 10'h0), '0);
        run_walk("fault_ptr_d", root_iova, 20'h00077, root, 1'b0);
        set_chain(root, root_iova, make_pte(44'h200, flag(PteV) | flag(PteU), 10'h0), '0, '0);
        run_walk("fault_ptr_u", root_iova, 20'h00088, root, 1'b0);
        set_chain(root, root_iova, ptr_to(44'h200), ptr_to(44'h300), ptr_to(44'h500));
        run_walk("fault_ptr_lvl3", root_iova, 20'h00099, root, 1'b0);
        set_chain(root, root_iova, make_pte(44'h200, flag(PteV), 10'h010), '0, '0);
        run_walk("fault_upper_ppn", root_iova, 20'h000aa, root, 1'b0);

        set_chain(root, root_iova, ptr_to(44'h200), ptr_to(44'h300), leaf_4k);
        run_walk("busy_miss", root_iova, 20'h000bb, root, 1'b1);
        run_hit("iotlb_hit");

        for (int i = 0; i < NumRandom; i++) begin
            iova = iova_t'({$urandom, $urandom});
            root = ppn_t'({$urandom, $urandom});
            set_chain(root, iova, rand_pte(2), rand_pte(1), rand_pte(0));
            run_walk($sformatf("random_%0d", i), iova, pscid_t'($urandom), root, 1'b0);
        end

        repeat (2) @(posedge clk_i);
        $display("tests %0d, errors %0d", done_count, errors + protocol_errors);
        if (errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/ptw_pkg.sv
design/ptw_ctrl.sv
design/ptw_ptr_gen.sv
design/pte_check.sv
design/iotlb_update_gen.sv
design/iommu_ptw_top.sv
dv/tb_iommu_ptw.sv

//--- run.sh
#!/bin/sh
# compile and run the walker testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_iommu_ptw -f sources.f \
    -o tb_iommu_ptw || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_iommu_ptw)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
